/* include/sccb_consts.svh */
`ifndef SCCB_CONSTS_SVH
`define SCCB_CONSTS_SVH

// clock cycles per quarter-bit tick.
`define SCCB_TICK_DIV 4

// idle ticks between two writes.
`define SCCB_GAP_TICKS 8

`define SCCB_TABLE_DEPTH 8

// sensor write address.
`define SCCB_DEV_ID 8'h42

`define SCCB_REG_CTRL   8'h00
`define SCCB_REG_STATUS 8'h04
`define SCCB_REG_COUNT  8'h08

`endif

/* logic/sccb_pkg.sv */
package sccb_pkg;

    // one table entry, also one write request.
    typedef struct packed {
        logic [7:0] reg_addr;
        logic [7:0] data;
    } sccb_write_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        M_IDLE,
        M_START,
        M_DATA,
        M_STOP
    } master_state_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT_DONE,
        S_GAP,
        S_FINISH
    } seq_state_e;

endpackage

/* logic/sccb_tick_gen.sv */
`timescale 1ns/1ps
`include "sccb_consts.svh"

module sccb_tick_gen (
    input  logic clk,
    input  logic reset,
    output logic tick
);
    localparam int CNT_W = (`SCCB_TICK_DIV > 2) ? $clog2(`SCCB_TICK_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SCCB_TICK_DIV - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            if (cnt == CNT_LAST) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            tick <= (cnt == CNT_LAST); // one cycle per period.
        end
    end

endmodule

/* logic/sccb_reg_rom.sv */
`timescale 1ns/1ps

module sccb_reg_rom (
    input  logic [2:0]            index,
    output sccb_pkg::sccb_write_t entry
);

    always_comb begin
        case (index)
            3'd0: begin
                entry.reg_addr = 8'h12; // COM7, soft reset.
                entry.data     = 8'h80;
            end
            3'd1: begin
                entry.reg_addr = 8'h11; // clock prescaler.
                entry.data     = 8'h01;
            end
            3'd2: begin
                entry.reg_addr = 8'h12;
                entry.data     = 8'h14;
            end
            3'd3: begin
                entry.reg_addr = 8'h40; // rgb565 output range.
                entry.data     = 8'hd0;
            end
            3'd4: begin
                entry.reg_addr = 8'h8c;
                entry.data     = 8'h00;
            end
            3'd5: begin
                entry.reg_addr = 8'h3a;
                entry.data     = 8'h04;
            end
            3'd6: begin
                entry.reg_addr = 8'h0c;
                entry.data     = 8'h00;
            end
            3'd7: begin
                // no pclk scaling.
                entry.reg_addr = 8'h3e;
                entry.data     = 8'h00;
            end
            default: begin
                entry.reg_addr = 8'h00;
                entry.data     = 8'h00;
            end
        endcase
    end

endmodule

/* logic/sccb_write_master.sv */
`timescale 1ns/1ps
`include "sccb_consts.svh"

module sccb_write_master (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  tick,
    input  logic                  req_valid,
    input  sccb_pkg::sccb_write_t req,
    output logic                  req_ready,
    output logic                  write_done,
    output logic                  scl,
    output logic                  sda
);
    localparam int FRAME_BITS = 27;
    localparam logic [4:0] LAST_BIT = 5'(FRAME_BITS - 1);

    sccb_pkg::master_state_e state;
    logic [1:0]              quarter;
    logic [4:0]              bit_cnt;
    logic [FRAME_BITS-1:0]   frame;
    logic                    accept;

    assign req_ready = (state == sccb_pkg::M_IDLE);
    assign accept    = req_valid && req_ready;

    // three phases, each byte followed by a released ninth bit.
    always_ff @(posedge clk) begin
        if (accept) begin
            frame <= {`SCCB_DEV_ID, 1'b1, req.reg_addr, 1'b1, req.data, 1'b1};
        end else if (tick && state == sccb_pkg::M_DATA && quarter == 2'd0) begin
            frame <= {frame[FRAME_BITS-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= sccb_pkg::M_IDLE;
            quarter    <= 2'd0;
            bit_cnt    <= 5'd0;
            scl        <= 1'b1;
            sda        <= 1'b1;
            write_done <= 1'b0;
        end else begin
            write_done <= 1'b0;
            case (state)
                sccb_pkg::M_IDLE: begin
                    quarter <= 2'd0;
                    bit_cnt <= 5'd0;
                    if (accept) begin
                        state <= sccb_pkg::M_START;
                    end
                end

                sccb_pkg::M_START: begin
                    if (tick) begin
                        if (quarter == 2'd0) begin
                            sda     <= 1'b0; // falls with scl high.
                            quarter <= 2'd1;
                        end else begin
                            scl     <= 1'b0;
                            quarter <= 2'd0;
                            state   <= sccb_pkg::M_DATA;
                        end
                    end
                end

                sccb_pkg::M_DATA: begin
                    if (tick) begin
                        quarter <= quarter + 2'd1;
                        case (quarter)
                            2'd0: sda <= frame[FRAME_BITS-1];
                            2'd1, 2'd2: scl <= 1'b1;
                            default: begin
                                scl <= 1'b0;
                                if (bit_cnt == LAST_BIT) begin
                                    bit_cnt <= 5'd0;
                                    state   <= sccb_pkg::M_STOP;
                                end else begin
                                    bit_cnt <= bit_cnt + 5'd1;
                                end
                            end
                        endcase
                    end
                end

                sccb_pkg::M_STOP: begin
                    if (tick) begin
                        quarter <= quarter + 2'd1;
                        case (quarter)
                            2'd0: sda <= 1'b0;
                            2'd1: scl <= 1'b1;
                            default: begin
                                sda        <= 1'b1; // rises after scl.
                                write_done <= 1'b1;
                                state      <= sccb_pkg::M_IDLE;
                            end
                        endcase
                    end
                end

                default: state <= sccb_pkg::M_IDLE;
            endcase
        end
    end

    idle_scl_high_a : assert property (
        @(posedge clk) disable iff (reset)
        (state == sccb_pkg::M_IDLE) |-> scl
    );

    // the sequencer must hold the entry until write_done.
    req_stable_a : assert property (
        @(posedge clk) disable iff (reset)
        (state != sccb_pkg::M_IDLE) |-> $stable(req)
    );

endmodule

/* logic/sccb_init_sequencer.sv */
`timescale 1ns/1ps
`include "sccb_consts.svh"

module sccb_init_sequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  tick,
    input  logic                  start_pulse,
    output logic [2:0]            index,
    input  sccb_pkg::sccb_write_t entry,
    output logic                  req_valid,
    output sccb_pkg::sccb_write_t req,
    input  logic                  req_ready,
    input  logic                  write_done,
    output logic                  busy,
    output logic                  done,
    output logic [3:0]            write_count
);
    localparam int GAP_W = (`SCCB_GAP_TICKS > 2) ? $clog2(`SCCB_GAP_TICKS) : 1;
    localparam logic [GAP_W-1:0] GAP_LAST  = GAP_W'(`SCCB_GAP_TICKS - 1);
    localparam logic [2:0]       LAST_IDX  = 3'(`SCCB_TABLE_DEPTH - 1);

    sccb_pkg::seq_state_e state;
    logic [GAP_W-1:0]     gap_cnt;

    assign req       = entry; // rom output held by a stable index.
    assign req_valid = (state == sccb_pkg::S_ISSUE);
    assign busy      = (state != sccb_pkg::S_IDLE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= sccb_pkg::S_IDLE;
            index       <= 3'd0;
            gap_cnt     <= '0;
            done        <= 1'b0;
            write_count <= 4'd0;
        end else begin
            case (state)
                sccb_pkg::S_IDLE: begin
                    if (start_pulse) begin
                        index       <= 3'd0;
                        done        <= 1'b0;
                        write_count <= 4'd0;
                        state       <= sccb_pkg::S_ISSUE;
                    end
                end
                sccb_pkg::S_ISSUE: begin
                    if (req_ready) state <= sccb_pkg::S_WAIT_DONE;
                end
                sccb_pkg::S_WAIT_DONE: begin
                    if (write_done) begin
                        write_count <= write_count + 4'd1;
                        gap_cnt     <= '0;
                        state       <= sccb_pkg::S_GAP;
                    end
                end
                sccb_pkg::S_GAP: begin
                    if (tick) begin
                        if (gap_cnt != GAP_LAST) begin
                            gap_cnt <= gap_cnt + 1'b1;
                        end else if (index == LAST_IDX) begin
                            state <= sccb_pkg::S_FINISH;
                        end else begin
                            index <= index + 3'd1;
                            state <= sccb_pkg::S_ISSUE;
                        end
                    end
                end
                default: begin // finish.
                    done  <= 1'b1;
                    state <= sccb_pkg::S_IDLE;
                end
            endcase
        end
    end

    count_bound_a : assert property (
        @(posedge clk) disable iff (reset)
        write_count <= 4'(`SCCB_TABLE_DEPTH)
    );

endmodule

/* logic/sccb_apb_regs.sv */
`timescale 1ns/1ps
`include "sccb_consts.svh"

module sccb_apb_regs (
    input  logic               clk,
    input  logic               reset,
    input  sccb_pkg::apb_req_t apb_req,
    output sccb_pkg::apb_rsp_t apb_rsp,
    output logic               start_pulse,
    input  logic               busy,
    input  logic               done,
    input  logic [3:0]         write_count
);
    logic access;
    logic addr_ok;

    assign access  = apb_req.psel && apb_req.penable;
    assign addr_ok = (apb_req.paddr == `SCCB_REG_CTRL)
                  || (apb_req.paddr == `SCCB_REG_STATUS)
                  || (apb_req.paddr == `SCCB_REG_COUNT);

    // sequencer drops it while busy.
    assign start_pulse = access && apb_req.pwrite
                      && (apb_req.paddr == `SCCB_REG_CTRL)
                      && apb_req.pwdata[0];

    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && !addr_ok;
        case (apb_req.paddr)
            `SCCB_REG_STATUS: apb_rsp.prdata = {30'd0, done, busy};
            `SCCB_REG_COUNT:  apb_rsp.prdata = {28'd0, write_count};
            default:          apb_rsp.prdata = 32'd0; // ctrl reads zero.
        endcase
    end

    penable_needs_psel_a : assert property (
        @(posedge clk) disable iff (reset)
        apb_req.penable |-> apb_req.psel
    );

    // the access phase always follows a setup phase.
    setup_before_access_a : assert property (
        @(posedge clk) disable iff (reset)
        (apb_req.psel && !apb_req.penable) |=> apb_req.penable
    );

endmodule

/* logic/camera_init_top.sv */
`timescale 1ns/1ps

module camera_init_top (
    input  logic               clk,
    input  logic               reset,
    input  sccb_pkg::apb_req_t apb_req,
    output sccb_pkg::apb_rsp_t apb_rsp,
    output logic               scl,
    output logic               sda
);
    logic                  start_pulse;
    logic                  busy;
    logic                  done;
    logic [3:0]            write_count;
    logic [2:0]            index;
    sccb_pkg::sccb_write_t entry;
    sccb_pkg::sccb_write_t req;
    logic                  req_valid;
    logic                  req_ready;
    logic                  write_done;
    logic                  tick;

    sccb_apb_regs u_apb_regs (
        .clk         (clk),
        .reset       (reset),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .start_pulse (start_pulse),
        .busy        (busy),
        .done        (done),
        .write_count (write_count)
    );

    sccb_init_sequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .tick        (tick),
        .start_pulse (start_pulse),
        .index       (index),
        .entry       (entry),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .write_done  (write_done),
        .busy        (busy),
        .done        (done),
        .write_count (write_count)
    );

    sccb_reg_rom u_rom (
        .index (index),
        .entry (entry)
    );

    sccb_tick_gen u_tick_gen (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    sccb_write_master u_master (
        .clk        (clk),
        .reset      (reset),
        .tick       (tick),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .write_done (write_done),
        .scl        (scl),
        .sda        (sda)
    );

endmodule

/* verification/sccb_bus_monitor.sv */
`timescale 1ns/1ps
`include "sccb_consts.svh"

module sccb_bus_monitor (
    input  logic       clk,
    input  logic       reset,
    input  logic       scl,
    input  logic       sda,
    output logic       start_seen,
    output logic       stop_seen,
    output logic       byte_valid,
    output logic [8:0] byte_data,
    output int         rule_errors
);
    localparam int GAP_MIN = (`SCCB_GAP_TICKS - 1) * `SCCB_TICK_DIV;

    logic       prev_scl;
    logic       prev_sda;
    logic       in_frame;
    logic       had_stop;
    logic [3:0] bit_cnt;
    logic [8:0] shift;
    int         idle_cycles;
    logic       start_cond;
    logic       stop_cond;
    logic       sda_moved_high;

    assign start_cond     = scl && prev_scl && prev_sda && !sda;
    assign stop_cond      = scl && prev_scl && !prev_sda && sda;
    assign sda_moved_high = scl && prev_scl && (sda != prev_sda);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prev_scl    <= 1'b1;
            prev_sda    <= 1'b1;
            in_frame    <= 1'b0;
            had_stop    <= 1'b0;
            bit_cnt     <= 4'd0;
            shift       <= 9'd0;
            idle_cycles <= 0;
            start_seen  <= 1'b0;
            stop_seen   <= 1'b0;
            byte_valid  <= 1'b0;
            byte_data   <= 9'd0;
            rule_errors <= 0;
        end else begin
            prev_scl   <= scl;
            prev_sda   <= sda;
            start_seen <= start_cond;
            stop_seen  <= stop_cond;
            byte_valid <= 1'b0;
            if (!in_frame && idle_cycles < GAP_MIN) idle_cycles <= idle_cycles + 1;
            if (start_cond) begin
                in_frame <= 1'b1;
                bit_cnt  <= 4'd0;
            end else if (stop_cond) begin
                in_frame    <= 1'b0;
                had_stop    <= 1'b1;
                idle_cycles <= 0;
            end else if (in_frame && scl && !prev_scl) begin
                shift <= {shift[7:0], sda}; // sampled on the scl rise.
                if (bit_cnt == 4'd8) begin
                    bit_cnt    <= 4'd0;
                    byte_valid <= 1'b1;
                    byte_data  <= {shift[7:0], sda};
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end

            // with scl high, sda may only fall on an idle bus or rise inside a frame.
            assert (!sda_moved_high || (start_cond && !in_frame) || (stop_cond && in_frame))
            else begin
                $display("monitor: sda moved while scl was high outside a start or stop");
                rule_errors <= rule_errors + 1;
            end
            assert (!((scl != prev_scl) && (sda != prev_sda)))
            else begin
                $display("monitor: scl and sda changed on the same cycle");
                rule_errors <= rule_errors + 1;
            end
            assert (in_frame || scl)
            else begin
                $display("monitor: scl went low on an idle bus");
                rule_errors <= rule_errors + 1;
            end
            assert (!(start_cond && had_stop) || idle_cycles >= GAP_MIN)
            else begin
                $display("monitor: start came only %0d cycles after a stop", idle_cycles);
                rule_errors <= rule_errors + 1;
            end
        end
    end

endmodule

/* verification/camera_init_tb.sv */
`timescale 1ns/1ps
`include "sccb_consts.svh"

module camera_init_tb;
    localparam int WAIT_LIMIT = `SCCB_TABLE_DEPTH * 160 * `SCCB_TICK_DIV; // status reads.

    logic               clk;
    logic               reset;
    sccb_pkg::apb_req_t apb_req;
    sccb_pkg::apb_rsp_t apb_rsp;
    logic               scl;
    logic               sda;
    logic               start_seen;
    logic               stop_seen;
    logic               byte_valid;
    logic [8:0]         byte_data;
    int                 mon_errors;
    logic [8:0]         got_bytes[$];
    int                 start_total = 0;
    int                 stop_total = 0;
    int                 errors = 0;
    int                 tests_failed = 0;
    bit                 timed_out = 0;

    // sensor table, entry by entry.
    logic [7:0] ref_addr [`SCCB_TABLE_DEPTH] =
        '{8'h12, 8'h11, 8'h12, 8'h40, 8'h8c, 8'h3a, 8'h0c, 8'h3e};
    logic [7:0] ref_data [`SCCB_TABLE_DEPTH] =
        '{8'h80, 8'h01, 8'h14, 8'hd0, 8'h00, 8'h04, 8'h00, 8'h00};

    camera_init_top u_dut (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .scl     (scl),
        .sda     (sda)
    );

    sccb_bus_monitor u_monitor (
        .clk         (clk),
        .reset       (reset),
        .scl         (scl),
        .sda         (sda),
        .start_seen  (start_seen),
        .stop_seen   (stop_seen),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .rule_errors (mon_errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (byte_valid) got_bytes.push_back(byte_data);
        if (start_seen) start_total++;
        if (stop_seen) stop_total++;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk); // response is settled before the completing edge.
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check_value("pready", 32'(apb_rsp.pready), 32'h1);
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, wdata, rdata, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata,
                            output logic err);
        apb_access(1'b0, addr, 32'h0, rdata, err);
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        logic        err;
        int          n;
        n  = 0;
        st = 32'h1;
        while (st[0] && n < WAIT_LIMIT) begin
            apb_read(`SCCB_REG_STATUS, st, err);
            n++;
        end
        if (st[0]) begin
            $display("timeout: sequencer still busy after %0d status reads", n);
            timed_out = 1'b1;
        end
    endtask

    // compares one full table replay starting at transaction first.
    task automatic check_run(input int first);
        int k;
        for (int i = 0; i < `SCCB_TABLE_DEPTH; i++) begin
            k = 3 * (first + i);
            check_value("dev_id byte", 32'(got_bytes[k]), 32'({`SCCB_DEV_ID, 1'b1}));
            check_value("reg_addr byte", 32'(got_bytes[k + 1]), 32'({ref_addr[i], 1'b1}));
            check_value("data byte", 32'(got_bytes[k + 2]), 32'({ref_data[i], 1'b1}));
        end
    endtask

    task automatic check_finished(input int runs);
        logic [31:0] rdata;
        logic        err;
        apb_read(`SCCB_REG_STATUS, rdata, err);
        check_value("status", rdata, 32'h2);
        apb_read(`SCCB_REG_COUNT, rdata, err);
        check_value("count", rdata, 32'(`SCCB_TABLE_DEPTH));
        check_value("start_total", 32'(start_total), 32'(runs * `SCCB_TABLE_DEPTH));
        check_value("stop_total", 32'(stop_total), 32'(runs * `SCCB_TABLE_DEPTH));
        check_value("byte total", 32'(got_bytes.size()), 32'(3 * runs * `SCCB_TABLE_DEPTH));
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail", name);
            tests_failed++;
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        int          e0;
        void'($urandom(32'h320a));
        reset   = 1'b1;
        apb_req = '0;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;

        e0 = errors;
        check_value("scl", 32'(scl), 32'h1);
        check_value("sda", 32'(sda), 32'h1);
        apb_read(`SCCB_REG_STATUS, rdata, err);
        check_value("status", rdata, 32'h0);
        apb_read(`SCCB_REG_COUNT, rdata, err);
        check_value("count", rdata, 32'h0);
        report_test("reset values", e0);

        e0 = errors;
        apb_write(`SCCB_REG_CTRL, 32'h1);
        apb_read(`SCCB_REG_STATUS, rdata, err);
        check_value("status while busy", rdata, 32'h1);
        apb_write(`SCCB_REG_CTRL, 32'h1); // lands mid-run, must be dropped.
        wait_idle();
        check_finished(1);
        check_run(0);
        report_test("first sequence", e0);

        e0 = errors;
        apb_read(8'h0c, rdata, err);
        check_value("pslverr", 32'(err), 32'h1);
        report_test("bad offset", e0);

        e0 = errors;
        repeat ($urandom_range(40, 2)) @(posedge clk);
        apb_write(`SCCB_REG_CTRL, 32'h1);
        apb_read(`SCCB_REG_STATUS, rdata, err);
        check_value("status after restart", rdata, 32'h1);
        wait_idle();
        check_finished(2);
        check_run(`SCCB_TABLE_DEPTH);
        report_test("second sequence", e0);

        e0 = errors;
        check_value("mon_errors", 32'(mon_errors), 32'h0);
        report_test("bus rules", e0);

        $display("tests failed: %0d of 5, check errors: %0d", tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
logic/sccb_pkg.sv
logic/sccb_tick_gen.sv
logic/sccb_reg_rom.sv
logic/sccb_write_master.sv
logic/sccb_init_sequencer.sv
logic/sccb_apb_regs.sv
logic/camera_init_top.sv
verification/sccb_bus_monitor.sv
verification/camera_init_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the camera init testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module camera_init_tb \
    -o camera_init_sim

out=$(./obj_dir/camera_init_sim)
echo "$out"
echo "$out" | grep -qx "TEST OK"
